// ==== source/VideoTxPkg.sv ====
//--------------------------------------------------------------------------
// Register map, widths and reset geometry for the TFT video transmitter
// Geometry defaults suit a 480x272 panel, Max values are total minus one
//--------------------------------------------------------------------------
package VideoTxPkg;

	//----------------------------------------------------------------------------
	// Widths
	//----------------------------------------------------------------------------
	localparam int lpHWidth		= 11;
	localparam int lpVWidth		= 11;
	localparam int lpColorDepth	= 4;		// Bits per channel on the pins
	localparam int lpAdrsWidth	= 8;

	//----------------------------------------------------------------------------
	// Reset geometry
	//----------------------------------------------------------------------------
	localparam int lpHdisplayDef	= 480;
	localparam int lpHSyncStartDef	= 488;		// Front porch 8
	localparam int lpHSyncEndDef	= 498;		// Pulse 10
	localparam int lpHMaxDef		= 540;		// Back porch 43
	localparam int lpVdisplayDef	= 272;
	localparam int lpVSyncStartDef	= 284;		// Front porch 12
	localparam int lpVSyncEndDef	= 294;		// Pulse 10
	localparam int lpVMaxDef		= 297;		// Back porch 4

	//----------------------------------------------------------------------------
	// Register addresses
	//----------------------------------------------------------------------------
	localparam logic [lpAdrsWidth-1:0] lpAdrsHdisplay	= 8'h00;
	localparam logic [lpAdrsWidth-1:0] lpAdrsHSyncStart	= 8'h01;
	localparam logic [lpAdrsWidth-1:0] lpAdrsHSyncEnd	= 8'h02;
	localparam logic [lpAdrsWidth-1:0] lpAdrsHMax		= 8'h03;
	localparam logic [lpAdrsWidth-1:0] lpAdrsVdisplay	= 8'h04;
	localparam logic [lpAdrsWidth-1:0] lpAdrsVSyncStart	= 8'h05;
	localparam logic [lpAdrsWidth-1:0] lpAdrsVSyncEnd	= 8'h06;
	localparam logic [lpAdrsWidth-1:0] lpAdrsVMax		= 8'h07;
	// Bit 0 video enable, bits 2:1 pattern mode
	localparam logic [lpAdrsWidth-1:0] lpAdrsCtrl		= 8'h08;
	localparam logic [lpAdrsWidth-1:0] lpAdrsColor		= 8'h09;	// RGB 4:4:4
	localparam logic [lpAdrsWidth-1:0] lpAdrsBlDuty		= 8'h0A;

	// Built-in pixel patterns
	typedef enum logic [1:0] {
		PatSolid	= 2'd0,
		PatBars		= 2'd1,
		PatChecker	= 2'd2,
		PatGradient	= 2'd3
	} patternMode_t;

endpackage

// ==== source/VideoTimingIf.sv ====
//--------------------------------------------------------------------------
// Timing, position and colour bundle between the video pipeline stages
// Syncs are active low
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface VideoTimingIf;

	logic								hSync;
	logic								vSync;
	logic								de;		// Display enable
	logic [VideoTxPkg::lpHWidth-1:0]	xPos;
	logic [VideoTxPkg::lpVWidth-1:0]	yPos;
	logic [VideoTxPkg::lpColorDepth-1:0]	colorR;
	logic [VideoTxPkg::lpColorDepth-1:0]	colorG;
	logic [VideoTxPkg::lpColorDepth-1:0]	colorB;

	// Timing generator side
	modport gen (output hSync, vSync, de, xPos, yPos);

	// Pattern stage, colour for the current position
	modport pix (input hSync, vSync, de, xPos, yPos, output colorR, colorG, colorB);

	// Registered stage output
	modport stage (output hSync, vSync, de, xPos, yPos, colorR, colorG, colorB);

	modport out (input hSync, vSync, de, xPos, yPos, colorR, colorG, colorB);

endinterface

// ==== source/VideoTxCsr.sv ====
//--------------------------------------------------------------------------
// Register space, writes take effect at the strobe edge
// Reads answer one cycle after rdEn, unmapped addresses read zero
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module VideoTxCsr (
	input  logic									iVideoClk,
	input  logic									arstN,
	input  logic									wrEn,
	input  logic [VideoTxPkg::lpAdrsWidth-1:0]		wrAdrs,
	input  logic [15:0]								wrData,
	input  logic									rdEn,
	input  logic [VideoTxPkg::lpAdrsWidth-1:0]		rdAdrs,
	output logic [15:0]								rdData,
	output logic									rdValid,
	output logic [VideoTxPkg::lpHWidth-1:0]			hDisplay,
	output logic [VideoTxPkg::lpHWidth-1:0]			hSyncStart,
	output logic [VideoTxPkg::lpHWidth-1:0]			hSyncEnd,
	output logic [VideoTxPkg::lpHWidth-1:0]			hMax,
	output logic [VideoTxPkg::lpVWidth-1:0]			vDisplay,
	output logic [VideoTxPkg::lpVWidth-1:0]			vSyncStart,
	output logic [VideoTxPkg::lpVWidth-1:0]			vSyncEnd,
	output logic [VideoTxPkg::lpVWidth-1:0]			vMax,
	output logic									videoEn,
	output VideoTxPkg::patternMode_t				patMode,
	output logic [11:0]								color,
	output logic [7:0]								blDuty
);

logic [15:0] rdMux;

//----------------------------------------------------------------------------
// Write decode
//----------------------------------------------------------------------------
always_ff @(posedge iVideoClk or negedge arstN)
begin
	if (!arstN)
	begin
		hDisplay	<= VideoTxPkg::lpHWidth'(VideoTxPkg::lpHdisplayDef);
		hSyncStart	<= VideoTxPkg::lpHWidth'(VideoTxPkg::lpHSyncStartDef);
		hSyncEnd	<= VideoTxPkg::lpHWidth'(VideoTxPkg::lpHSyncEndDef);
		hMax		<= VideoTxPkg::lpHWidth'(VideoTxPkg::lpHMaxDef);
		vDisplay	<= VideoTxPkg::lpVWidth'(VideoTxPkg::lpVdisplayDef);
		vSyncStart	<= VideoTxPkg::lpVWidth'(VideoTxPkg::lpVSyncStartDef);
		vSyncEnd	<= VideoTxPkg::lpVWidth'(VideoTxPkg::lpVSyncEndDef);
		vMax		<= VideoTxPkg::lpVWidth'(VideoTxPkg::lpVMaxDef);
		videoEn		<= 1'b0;
		patMode		<= VideoTxPkg::PatSolid;
		color		<= '0;
		blDuty		<= '0;		// Backlight off
	end
	else if (wrEn)
	begin
		case (wrAdrs)
			VideoTxPkg::lpAdrsHdisplay:		hDisplay	<= wrData[VideoTxPkg::lpHWidth-1:0];
			VideoTxPkg::lpAdrsHSyncStart:	hSyncStart	<= wrData[VideoTxPkg::lpHWidth-1:0];
			VideoTxPkg::lpAdrsHSyncEnd:		hSyncEnd	<= wrData[VideoTxPkg::lpHWidth-1:0];
			VideoTxPkg::lpAdrsHMax:			hMax		<= wrData[VideoTxPkg::lpHWidth-1:0];
			VideoTxPkg::lpAdrsVdisplay:		vDisplay	<= wrData[VideoTxPkg::lpVWidth-1:0];
			VideoTxPkg::lpAdrsVSyncStart:	vSyncStart	<= wrData[VideoTxPkg::lpVWidth-1:0];
			VideoTxPkg::lpAdrsVSyncEnd:		vSyncEnd	<= wrData[VideoTxPkg::lpVWidth-1:0];
			VideoTxPkg::lpAdrsVMax:			vMax		<= wrData[VideoTxPkg::lpVWidth-1:0];
			VideoTxPkg::lpAdrsCtrl:
			begin
				videoEn	<= wrData[0];
				patMode	<= VideoTxPkg::patternMode_t'(wrData[2:1]);
			end
			VideoTxPkg::lpAdrsColor:		color		<= wrData[11:0];
			VideoTxPkg::lpAdrsBlDuty:		blDuty		<= wrData[7:0];
			default:						;			// Unmapped, ignored
		endcase
	end
end

//----------------------------------------------------------------------------
// Read back
//----------------------------------------------------------------------------
always_comb
begin
	case (rdAdrs)
		VideoTxPkg::lpAdrsHdisplay:		rdMux = 16'(hDisplay);
		VideoTxPkg::lpAdrsHSyncStart:	rdMux = 16'(hSyncStart);
		VideoTxPkg::lpAdrsHSyncEnd:		rdMux = 16'(hSyncEnd);
		VideoTxPkg::lpAdrsHMax:			rdMux = 16'(hMax);
		VideoTxPkg::lpAdrsVdisplay:		rdMux = 16'(vDisplay);
		VideoTxPkg::lpAdrsVSyncStart:	rdMux = 16'(vSyncStart);
		VideoTxPkg::lpAdrsVSyncEnd:		rdMux = 16'(vSyncEnd);
		VideoTxPkg::lpAdrsVMax:			rdMux = 16'(vMax);
		VideoTxPkg::lpAdrsCtrl:			rdMux = {13'd0, patMode, videoEn};
		VideoTxPkg::lpAdrsColor:		rdMux = {4'd0, color};
		VideoTxPkg::lpAdrsBlDuty:		rdMux = {8'd0, blDuty};
		default:						rdMux = '0;
	endcase
end

always_ff @(posedge iVideoClk or negedge arstN)
begin
	if (!arstN)
	begin
		rdValid	<= 1'b0;
		rdData	<= '0;
	end
	else
	begin
		rdValid	<= rdEn;		// Exactly one cycle per strobe
		if (rdEn)
			rdData	<= rdMux;
	end
end

endmodule

// ==== source/VideoTimingGen.sv ====
//--------------------------------------------------------------------------
// Horizontal and vertical counters with registered sync and display enable
// Geometry is expected to change only while video is disabled
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module VideoTimingGen (
	input  logic								iVideoClk,
	input  logic								arstN,
	input  logic								videoEn,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hDisplay,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hSyncStart,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hSyncEnd,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hMax,
	input  logic [VideoTxPkg::lpVWidth-1:0]		vDisplay,
	input  logic [VideoTxPkg::lpVWidth-1:0]		vSyncStart,
	input  logic [VideoTxPkg::lpVWidth-1:0]		vSyncEnd,
	input  logic [VideoTxPkg::lpVWidth-1:0]		vMax,
	VideoTimingIf.gen							tim
);

logic [VideoTxPkg::lpHWidth-1:0]	hCount;
logic [VideoTxPkg::lpHWidth-1:0]	hNext;
logic [VideoTxPkg::lpVWidth-1:0]	vCount;
logic [VideoTxPkg::lpVWidth-1:0]	vNext;
logic								hWrap;
logic								running;	// Enable seen for a cycle
logic								hSyncReg;
logic								vSyncReg;
logic								deReg;

assign hWrap = (hCount == hMax);

// Counters sit at zero for one cycle after enable, so de lines up at 0,0
always_comb
begin
	hNext = '0;
	vNext = '0;
	if (videoEn && running)
	begin
		hNext = hWrap ? '0 : hCount + 1'b1;
		if (hWrap)
			vNext = (vCount == vMax) ? '0 : vCount + 1'b1;
		else
			vNext = vCount;
	end
end

// Sync and de are decoded from the next count, so they match the counters
always_ff @(posedge iVideoClk or negedge arstN)
begin
	if (!arstN)
	begin
		running		<= 1'b0;
		hCount		<= '0;
		vCount		<= '0;
		hSyncReg	<= 1'b1;
		vSyncReg	<= 1'b1;
		deReg		<= 1'b0;
	end
	else
	begin
		running		<= videoEn;
		hCount		<= hNext;
		vCount		<= vNext;
		deReg		<= videoEn && (hNext < hDisplay) && (vNext < vDisplay);
		hSyncReg	<= !(videoEn && (hNext >= hSyncStart) && (hNext < hSyncEnd));
		vSyncReg	<= !(videoEn && (vNext >= vSyncStart) && (vNext < vSyncEnd));
	end
end

assign tim.hSync	= hSyncReg;
assign tim.vSync	= vSyncReg;
assign tim.de		= deReg;
assign tim.xPos		= hCount;
assign tim.yPos		= vCount;

endmodule

// ==== source/PixelPattern.sv ====
//--------------------------------------------------------------------------
// Pattern stage, one cycle of latency with timing delayed alongside colour
// Colour is black outside the active area
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module PixelPattern (
	input  logic							iVideoClk,
	input  logic							arstN,
	input  VideoTxPkg::patternMode_t		patMode,
	input  logic [11:0]						color,
	VideoTimingIf.pix						timIn,
	VideoTimingIf.stage						timOut
);

logic [VideoTxPkg::lpColorDepth-1:0]	red;
logic [VideoTxPkg::lpColorDepth-1:0]	green;
logic [VideoTxPkg::lpColorDepth-1:0]	blue;
logic [2:0]								barIdx;

assign barIdx = timIn.xPos[3:1];		// Eight bars, two pixels each

always_comb
begin
	red		= '0;
	green	= '0;
	blue	= '0;
	if (timIn.de)
	begin
		case (patMode)
			VideoTxPkg::PatSolid:	{red, green, blue} = color;
			VideoTxPkg::PatBars:
			begin
				red		= {VideoTxPkg::lpColorDepth{barIdx[2]}};
				green	= {VideoTxPkg::lpColorDepth{barIdx[1]}};
				blue	= {VideoTxPkg::lpColorDepth{barIdx[0]}};
			end
			VideoTxPkg::PatChecker:
			begin
				if (timIn.xPos[2] ^ timIn.yPos[2])
					{red, green, blue} = color;
			end
			VideoTxPkg::PatGradient:
			begin
				red		= timIn.xPos[VideoTxPkg::lpColorDepth-1:0];
				green	= timIn.yPos[VideoTxPkg::lpColorDepth-1:0];
				blue	= timIn.xPos[VideoTxPkg::lpColorDepth-1:0]
						^ timIn.yPos[VideoTxPkg::lpColorDepth-1:0];
			end
			default:	;
		endcase
	end
end

// Unregistered colour for the current position
assign timIn.colorR	= red;
assign timIn.colorG	= green;
assign timIn.colorB	= blue;

always_ff @(posedge iVideoClk or negedge arstN)
begin
	if (!arstN)
	begin
		timOut.hSync	<= 1'b1;
		timOut.vSync	<= 1'b1;
		timOut.de		<= 1'b0;
	end
	else
	begin
		timOut.hSync	<= timIn.hSync;
		timOut.vSync	<= timIn.vSync;
		timOut.de		<= timIn.de;
	end
end

always_ff @(posedge iVideoClk)
begin
	timOut.xPos		<= timIn.xPos;
	timOut.yPos		<= timIn.yPos;
	timOut.colorR	<= red;
	timOut.colorG	<= green;
	timOut.colorB	<= blue;
end

endmodule

// ==== source/TftOutput.sv ====
//--------------------------------------------------------------------------
// TFT pin register stage and backlight PWM with a 256-cycle period
// tftDclk is the inverted video clock, so data is centred on its edge
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module TftOutput (
	input  logic									iVideoClk,
	input  logic									arstN,
	input  logic									videoEn,
	input  logic [7:0]								blDuty,
	VideoTimingIf.out								timIn,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorR,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorG,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorB,
	output logic									tftDclk,
	output logic									tftHSync,
	output logic									tftVSync,
	output logic									tftDe,
	output logic									tftBackLight,
	output logic									tftRst
);

logic [7:0] pwmCount;		// Free running

assign tftDclk = ~iVideoClk;

always_ff @(posedge iVideoClk or negedge arstN)
begin
	if (!arstN)
	begin
		tftColorR		<= '0;
		tftColorG		<= '0;
		tftColorB		<= '0;
		tftHSync		<= 1'b1;
		tftVSync		<= 1'b1;
		tftDe			<= 1'b0;
		pwmCount		<= '0;
		tftBackLight	<= 1'b0;
		tftRst			<= 1'b0;		// Panel held in reset
	end
	else
	begin
		tftColorR		<= timIn.colorR;
		tftColorG		<= timIn.colorG;
		tftColorB		<= timIn.colorB;
		tftHSync		<= timIn.hSync;
		tftVSync		<= timIn.vSync;
		tftDe			<= timIn.de;
		pwmCount		<= pwmCount + 1'b1;
		tftBackLight	<= (pwmCount < blDuty);	// blDuty highs per period
		tftRst			<= videoEn;
	end
end

endmodule

// ==== source/VideoTxBlock.sv ====
//--------------------------------------------------------------------------
// Video transmitter top, register bus and TFT pins on one clock
// Counter to pins takes two cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module VideoTxBlock (
	input  logic									iVideoClk,
	input  logic									arstN,
	input  logic									wrEn,
	input  logic [VideoTxPkg::lpAdrsWidth-1:0]		wrAdrs,
	input  logic [15:0]								wrData,
	input  logic									rdEn,
	input  logic [VideoTxPkg::lpAdrsWidth-1:0]		rdAdrs,
	output logic [15:0]								rdData,
	output logic									rdValid,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorR,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorG,
	output logic [VideoTxPkg::lpColorDepth-1:0]		tftColorB,
	output logic									tftDclk,
	output logic									tftHSync,
	output logic									tftVSync,
	output logic									tftDe,
	output logic									tftBackLight,
	output logic									tftRst
);

logic [VideoTxPkg::lpHWidth-1:0]	hDisplay, hSyncStart, hSyncEnd, hMax;
logic [VideoTxPkg::lpVWidth-1:0]	vDisplay, vSyncStart, vSyncEnd, vMax;
logic								videoEn;
VideoTxPkg::patternMode_t			patMode;
logic [11:0]						color;
logic [7:0]							blDuty;

VideoTimingIf timGenIf ();		// Counter stage to pattern stage
VideoTimingIf timPixIf ();		// Pattern stage to pins

//----------------------------------------------------------------------------
// Register space
//----------------------------------------------------------------------------
VideoTxCsr u_VideoTxCsr (
	.iVideoClk	(iVideoClk),	.arstN		(arstN),
	.wrEn		(wrEn),			.wrAdrs		(wrAdrs),		.wrData		(wrData),
	.rdEn		(rdEn),			.rdAdrs		(rdAdrs),
	.rdData		(rdData),		.rdValid	(rdValid),
	.hDisplay	(hDisplay),		.hSyncStart	(hSyncStart),
	.hSyncEnd	(hSyncEnd),		.hMax		(hMax),
	.vDisplay	(vDisplay),		.vSyncStart	(vSyncStart),
	.vSyncEnd	(vSyncEnd),		.vMax		(vMax),
	.videoEn	(videoEn),		.patMode	(patMode),
	.color		(color),		.blDuty		(blDuty)
);

//----------------------------------------------------------------------------
// Pipeline
//----------------------------------------------------------------------------
VideoTimingGen u_VideoTimingGen (
	.iVideoClk	(iVideoClk),	.arstN		(arstN),		.videoEn	(videoEn),
	.hDisplay	(hDisplay),		.hSyncStart	(hSyncStart),
	.hSyncEnd	(hSyncEnd),		.hMax		(hMax),
	.vDisplay	(vDisplay),		.vSyncStart	(vSyncStart),
	.vSyncEnd	(vSyncEnd),		.vMax		(vMax),
	.tim		(timGenIf)
);

PixelPattern u_PixelPattern (
	.iVideoClk	(iVideoClk),	.arstN		(arstN),
	.patMode	(patMode),		.color		(color),
	.timIn		(timGenIf),		.timOut		(timPixIf)
);

TftOutput u_TftOutput (
	.iVideoClk		(iVideoClk),	.arstN		(arstN),
	.videoEn		(videoEn),		.blDuty		(blDuty),
	.timIn			(timPixIf),
	.tftColorR		(tftColorR),	.tftColorG	(tftColorG),	.tftColorB	(tftColorB),
	.tftDclk		(tftDclk),		.tftHSync	(tftHSync),		.tftVSync	(tftVSync),
	.tftDe			(tftDe),		.tftBackLight	(tftBackLight),
	.tftRst			(tftRst)
);

endmodule

// ==== bench/VideoTxBlock_asserts.sv ====
//--------------------------------------------------------------------------
// Concurrent checks bound into the video transmitter top
// Sync rule holds only for geometry with hSyncStart at or past hDisplay
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module VideoTxBlockAsserts (
	input  logic								iVideoClk,
	input  logic								arstN,
	input  logic								rdEn,
	input  logic								rdValid,
	input  logic								de,
	input  logic								hSync,
	input  logic [VideoTxPkg::lpHWidth-1:0]		xPos,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hDisplay,
	input  logic [VideoTxPkg::lpHWidth-1:0]		hSyncStart
);

// Active area only
deInsideLine: assert property (@(posedge iVideoClk) disable iff (!arstN)
	de |-> (xPos < hDisplay))
	else $error("de high at column %0d, active width %0d", xPos, hDisplay);

// No sync pulse inside the active area
syncOutsideActive: assert property (@(posedge iVideoClk) disable iff (!arstN)
	(de && (hSyncStart >= hDisplay)) |-> hSync)
	else $error("hSync low while de is high at column %0d", xPos);

rdValidFollowsRead: assert property (@(posedge iVideoClk) disable iff (!arstN)
	rdValid |-> $past(rdEn))
	else $error("rdValid high without a read strobe one cycle before");

endmodule

bind VideoTxBlock VideoTxBlockAsserts u_VideoTxBlockAsserts (
	.iVideoClk	(iVideoClk),
	.arstN		(arstN),
	.rdEn		(rdEn),
	.rdValid	(rdValid),
	.de			(timGenIf.de),
	.hSync		(timGenIf.hSync),
	.xPos		(timGenIf.xPos),
	.hDisplay	(hDisplay),
	.hSyncStart	(hSyncStart)
);

// ==== bench/VideoTxBlockTb.sv ====
//--------------------------------------------------------------------------
// Testbench for the TFT video transmitter, programs a 24x12 frame
// Outputs are sampled on the falling clock edge, inputs driven on the rising
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module VideoTxBlockTb;

// Programmed geometry
localparam int lpHDisp		= 16;
localparam int lpHSyncStart	= 18;
localparam int lpHSyncEnd	= 20;
localparam int lpHMax		= 23;
localparam int lpVDisp		= 8;
localparam int lpVSyncStart	= 9;
localparam int lpVSyncEnd	= 10;
localparam int lpVMax		= 11;
localparam int lpLine		= lpHMax + 1;
localparam int lpFrame		= lpLine * (lpVMax + 1);		// 288 cycles
localparam int lpTimeout	= 12 * lpFrame + 600;
localparam int unsigned lpSeed	= 32'h06b10d9e;
localparam int lpTableLen	= 8;

logic										videoClk = 1'b0;
logic										arstN;
logic										wrEn;
logic [VideoTxPkg::lpAdrsWidth-1:0]			wrAdrs;
logic [15:0]								wrData;
logic										rdEn;
logic [VideoTxPkg::lpAdrsWidth-1:0]			rdAdrs;
logic [15:0]								rdData;
logic										rdValid;
logic [3:0]									tftColorR;
logic [3:0]									tftColorG;
logic [3:0]									tftColorB;
logic										tftDclk;
logic										tftHSync;
logic										tftVSync;
logic										tftDe;
logic										tftBackLight;
logic										tftRst;

int		errors = 0;
int		checks = 0;
int		tests = 0;
int		testErrStart = 0;
string	curTest = "";
int		cycle = 0;

// Pixel model and frame statistics
logic			pixOn = 1'b0;
logic			frameOn = 1'b0;
int				modelX = 0;
int				modelY = 0;
int				deCount = 0;
int				hLowLen = 0;
int				vLowLen = 0;
int				lastHFall = -1;
int				vRises = 0;
logic			prevH = 1'b1;
logic			prevV = 1'b1;
int				curMode = 0;
logic [11:0]	solidColor;
logic [7:0]		blDutyVal;

//----------------------------------------------------------------------------
// Write and read-back table
//----------------------------------------------------------------------------
string			tblName [lpTableLen] = '{"hdisplay", "hmax truncated", "vsync end",
	"ctrl mode", "ctrl upper bits", "color", "backlight duty", "unmapped"};
logic [7:0]		tblAdrs [lpTableLen] = '{8'h00, 8'h03, 8'h06, 8'h08, 8'h08, 8'h09,
	8'h0A, 8'h0B};
logic [15:0]	tblData [lpTableLen] = '{16'h0123, 16'hFFFF, 16'h0155, 16'h0006,
	16'hFFF8, 16'hABCD, 16'h1234, 16'hBEEF};
logic [15:0]	tblExp [lpTableLen] = '{16'h0123, 16'h07FF, 16'h0155, 16'h0006,
	16'h0000, 16'h0BCD, 16'h0034, 16'h0000};

string			patName [4] = '{"pattern solid", "pattern bars", "pattern checker",
	"pattern gradient"};

always #50 videoClk = ~videoClk;

VideoTxBlock u_VideoTxBlock (
	.iVideoClk		(videoClk),		.arstN			(arstN),
	.wrEn			(wrEn),			.wrAdrs			(wrAdrs),		.wrData		(wrData),
	.rdEn			(rdEn),			.rdAdrs			(rdAdrs),
	.rdData			(rdData),		.rdValid		(rdValid),
	.tftColorR		(tftColorR),	.tftColorG		(tftColorG),	.tftColorB	(tftColorB),
	.tftDclk		(tftDclk),		.tftHSync		(tftHSync),		.tftVSync	(tftVSync),
	.tftDe			(tftDe),		.tftBackLight	(tftBackLight),	.tftRst		(tftRst)
);

//----------------------------------------------------------------------------
// Helpers
//----------------------------------------------------------------------------
task automatic check(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	checks++;
	if (expected !== actual)
	begin
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		errors++;
	end
endtask

task automatic beginTest(input string name);
	curTest = name;
	testErrStart = errors;
endtask

task automatic endTest();
	tests++;
	if (errors == testErrStart)
		$display("Test %s: ok", curTest);
	else
		$display("Test %s: %0d error(s)", curTest, errors - testErrStart);
endtask

task automatic waitCycles(input int n);
	repeat (n) @(posedge videoClk);
endtask

task automatic writeReg(input logic [7:0] adrs, input logic [15:0] data);
	@(posedge videoClk);
	wrEn	<= 1'b1;
	wrAdrs	<= adrs;
	wrData	<= data;
	@(posedge videoClk);
	wrEn	<= 1'b0;
endtask

// Data is due exactly one cycle after the strobe
task automatic readReg(input string name, input logic [7:0] adrs, output logic [15:0] data);
	@(posedge videoClk);
	rdEn	<= 1'b1;
	rdAdrs	<= adrs;
	@(posedge videoClk);
	rdEn	<= 1'b0;
	@(negedge videoClk);
	data = rdData;
	check({name, " rdValid"}, 32'd1, 32'(rdValid));
	@(negedge videoClk);
	check({name, " rdValid single"}, 32'd0, 32'(rdValid));
endtask

task automatic expectRead(input string name, input logic [7:0] adrs,
	input logic [15:0] expected);
	logic [15:0] data;
	readReg(name, adrs, data);
	check(name, 32'(expected), 32'(data));
endtask

// Colour rule of each built-in pattern
function automatic logic [11:0] expectedColor(input int mode, input int x, input int y,
	input logic [11:0] solid);
	logic [2:0] bar;
	logic [3:0] xl;
	logic [3:0] yl;
	bar	= 3'((x / 2) % 8);
	xl	= 4'(x % 16);
	yl	= 4'(y % 16);
	case (mode)
		int'(VideoTxPkg::PatSolid):		return solid;
		int'(VideoTxPkg::PatBars):		return {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
		int'(VideoTxPkg::PatChecker):	return (((x / 4) + (y / 4)) % 2 == 1) ? solid : 12'h000;
		default:						return {xl, yl, xl ^ yl};
	endcase
endfunction

// Restart video from idle and run until the vSync pulse of that frame ends
task automatic runFrame(input int mode, input logic checkPixels);
	int risesAtStart;
	writeReg(VideoTxPkg::lpAdrsCtrl, 16'(mode * 2));
	waitCycles(4);		// Pins back to idle
	modelX		= 0;
	modelY		= 0;
	deCount		= 0;
	lastHFall	= -1;
	curMode		= mode;
	risesAtStart	= vRises;
	frameOn		= 1'b1;
	pixOn		= checkPixels;
	writeReg(VideoTxPkg::lpAdrsCtrl, 16'(mode * 2 + 1));
	while (vRises == risesAtStart)
		@(posedge videoClk);
	frameOn	= 1'b0;
	pixOn	= 1'b0;
	check({curTest, " de cycles"}, 32'(lpHDisp * lpVDisp), 32'(deCount));
endtask

//----------------------------------------------------------------------------
// Pin monitor, pixel model and sync timing
//----------------------------------------------------------------------------
always @(negedge videoClk)
begin
	if (tftDe)
	begin
		if (pixOn)
			check($sformatf("%s x%0d y%0d", curTest, modelX, modelY),
				32'(expectedColor(curMode, modelX, modelY, solidColor)),
				32'({tftColorR, tftColorG, tftColorB}));
		modelX	= modelX + 1;
		deCount	= deCount + 1;
	end
	if (prevH && !tftHSync)
	begin
		if (modelX != 0)
			modelY = modelY + 1;		// Line had pixels
		modelX = 0;
		if (frameOn && lastHFall >= 0)
			check({curTest, " hsync period"}, 32'(lpLine), 32'(cycle - lastHFall));
		lastHFall	= cycle;
		hLowLen		= 0;
	end
	if (!prevH && tftHSync && frameOn)
		check({curTest, " hsync width"}, 32'(lpHSyncEnd - lpHSyncStart), 32'(hLowLen));
	if (!tftHSync)
		hLowLen = hLowLen + 1;
	if (prevV && !tftVSync)
	begin
		modelY	= 0;
		vLowLen	= 0;
	end
	if (!prevV && tftVSync)
	begin
		if (frameOn)
			check({curTest, " vsync width"}, 32'((lpVSyncEnd - lpVSyncStart) * lpLine),
				32'(vLowLen));
		vRises = vRises + 1;
	end
	if (!tftVSync)
		vLowLen = vLowLen + 1;
	prevH = tftHSync;
	prevV = tftVSync;
end

// Run limit
always @(posedge videoClk)
begin
	cycle <= cycle + 1;
	if (cycle >= lpTimeout)
	begin
		$display("Timeout after %0d cycles, the tests did not complete", cycle);
		$display("Regression failed");
		$finish;
	end
end

//----------------------------------------------------------------------------
// Test sequence
//----------------------------------------------------------------------------
initial
begin
	int bad;
	int highs;
	arstN	= 1'b0;
	wrEn	= 1'b0;
	wrAdrs	= '0;
	wrData	= '0;
	rdEn	= 1'b0;
	rdAdrs	= '0;
	void'($urandom(lpSeed));
	solidColor	= 12'($urandom);
	blDutyVal	= 8'($urandom);
	repeat (16) @(posedge videoClk);
	arstN <= 1'b1;
	@(negedge videoClk);

	beginTest("reset defaults");
	check("reset tftDe", 32'd0, 32'(tftDe));
	check("reset tftHSync", 32'd1, 32'(tftHSync));
	check("reset tftVSync", 32'd1, 32'(tftVSync));
	check("reset rdValid", 32'd0, 32'(rdValid));
	check("reset tftBackLight", 32'd0, 32'(tftBackLight));
	check("reset tftRst", 32'd0, 32'(tftRst));
	// Pixel clock is the inverted video clock, sampled mid phase
	#25;
	check("tftDclk low phase", 32'd1, 32'(tftDclk));
	@(posedge videoClk);
	#25;
	check("tftDclk high phase", 32'd0, 32'(tftDclk));
	expectRead("default hdisplay", VideoTxPkg::lpAdrsHdisplay, 16'(VideoTxPkg::lpHdisplayDef));
	expectRead("default hsyncstart", VideoTxPkg::lpAdrsHSyncStart,
		16'(VideoTxPkg::lpHSyncStartDef));
	expectRead("default hsyncend", VideoTxPkg::lpAdrsHSyncEnd, 16'(VideoTxPkg::lpHSyncEndDef));
	expectRead("default hmax", VideoTxPkg::lpAdrsHMax, 16'(VideoTxPkg::lpHMaxDef));
	expectRead("default vdisplay", VideoTxPkg::lpAdrsVdisplay, 16'(VideoTxPkg::lpVdisplayDef));
	expectRead("default vsyncstart", VideoTxPkg::lpAdrsVSyncStart,
		16'(VideoTxPkg::lpVSyncStartDef));
	expectRead("default vsyncend", VideoTxPkg::lpAdrsVSyncEnd, 16'(VideoTxPkg::lpVSyncEndDef));
	expectRead("default vmax", VideoTxPkg::lpAdrsVMax, 16'(VideoTxPkg::lpVMaxDef));
	endTest();

	beginTest("register table");
	for (int i = 0; i < lpTableLen; i++)
	begin
		writeReg(tblAdrs[i], tblData[i]);
		expectRead(tblName[i], tblAdrs[i], tblExp[i]);
	end
	endTest();

	beginTest("frame geometry");
	writeReg(VideoTxPkg::lpAdrsCtrl, 16'h0000);
	writeReg(VideoTxPkg::lpAdrsHdisplay, 16'(lpHDisp));
	writeReg(VideoTxPkg::lpAdrsHSyncStart, 16'(lpHSyncStart));
	writeReg(VideoTxPkg::lpAdrsHSyncEnd, 16'(lpHSyncEnd));
	writeReg(VideoTxPkg::lpAdrsHMax, 16'(lpHMax));
	writeReg(VideoTxPkg::lpAdrsVdisplay, 16'(lpVDisp));
	writeReg(VideoTxPkg::lpAdrsVSyncStart, 16'(lpVSyncStart));
	writeReg(VideoTxPkg::lpAdrsVSyncEnd, 16'(lpVSyncEnd));
	writeReg(VideoTxPkg::lpAdrsVMax, 16'(lpVMax));
	runFrame(int'(VideoTxPkg::PatSolid), 1'b0);
	endTest();

	writeReg(VideoTxPkg::lpAdrsColor, 16'(solidColor));
	for (int m = 0; m < 4; m++)
	begin
		beginTest(patName[m]);
		runFrame(m, 1'b1);
		endTest();
	end

	beginTest("backlight");
	writeReg(VideoTxPkg::lpAdrsBlDuty, 16'(blDutyVal));
	waitCycles(3);
	highs = 0;
	repeat (256)
	begin
		@(negedge videoClk);
		if (tftBackLight)
			highs++;
	end
	check("backlight duty", 32'(blDutyVal), 32'(highs));
	endTest();

	beginTest("disable");
	writeReg(VideoTxPkg::lpAdrsCtrl, 16'(int'(VideoTxPkg::PatBars) * 2 + 1));
	waitCycles(3);
	@(negedge videoClk);
	check("enabled tftRst", 32'd1, 32'(tftRst));
	waitCycles(40);
	writeReg(VideoTxPkg::lpAdrsCtrl, 16'h0000);
	waitCycles(4);
	bad = 0;
	repeat (lpFrame + lpLine)
	begin
		@(negedge videoClk);
		if (tftDe || !tftHSync || !tftVSync || tftRst)
			bad++;
	end
	check("disabled idle pins", 32'd0, 32'(bad));
	endTest();

	$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
	if (errors == 0)
		$display("Regression passed");
	else
		$display("Regression failed");
	$finish;
end

endmodule

// ==== filelist.f ====
source/VideoTxPkg.sv
source/VideoTimingIf.sv
source/VideoTxCsr.sv
source/VideoTimingGen.sv
source/PixelPattern.sv
source/TftOutput.sv
source/VideoTxBlock.sv
bench/VideoTxBlock_asserts.sv
bench/VideoTxBlockTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
TOP        := VideoTxBlockTb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
SIM        := $(BUILD_DIR)/V$(TOP)
LOG        := sim.log
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
